// File: opb_adc3w_ctrl.f
+incdir+design
design/adc3w_pkg.sv
design/adc3w_cfg_if.sv
design/adc3w_cmd_if.sv
design/opb_adc_regs.sv
design/adc_cmd_slot.sv
design/adc3wire_engine.sv
design/opb_adc3w_ctrl.sv
tests/adc3w_slave_model.sv
tests/tb_opb_adc3w_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f opb_adc3w_ctrl.f \
  --top-module tb_opb_adc3w_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_opb_adc3w_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "^all tests passed$" sim.log; then
  exit 0
fi
exit 1

// File: tests/tb_opb_adc3w_ctrl.sv
////////////////////////////////////////
// testbench for the opb adc controller
////////////////////////////////////////
`include "adc3w_defs.svh"

module tb_opb_adc3w_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int XFER_CYCLES = 26 * 32 + 64;  // one serial transaction, with margin
  localparam real TIMEOUT_NS = 60.0 * XFER_CYCLES * 100.0;

  logic        OPB_Clk;
  logic        rst_n;
  logic [31:0] opb_abus;
  logic [3:0]  opb_be;
  logic [31:0] opb_dbus;
  logic        opb_rnw;
  logic        opb_select;
  logic [31:0] sl_dbus;
  logic        sl_xfer_ack;
  logic        adc_reset;
  logic        adc_dcm_locked;
  logic        adc_sclk;
  logic        adc_sdata;
  logic        adc_sdata_in;
  logic        adc_modepin;
  logic [7:0]  m_addr;
  logic [15:0] m_data;
  int          m_writes;
  logic [15:0] lfsr_q;

  opb_adc3w_ctrl dut0 (.*);

  adc3w_slave_model model0 (
    .adc_sclk     (adc_sclk),
    .adc_sdata    (adc_sdata),
    .adc_modepin  (adc_modepin),
    .adc_sdata_in (adc_sdata_in),
    .last_addr    (m_addr),
    .last_data    (m_data),
    .write_count  (m_writes)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #50 OPB_Clk = ~OPB_Clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      stop_run("value mismatch");
    end
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[14:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // one bus transfer, select held until ack
  task automatic bus_xfer(input logic rnw, input logic [29:0] reg_off, input logic [3:0] be,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge OPB_Clk);
    #1;
    opb_abus   = `ADC3W_BASE_ADDR + {reg_off, 2'b00};
    opb_be     = be;
    opb_dbus   = wdata;
    opb_rnw    = rnw;
    opb_select = 1'b1;
    do @(negedge OPB_Clk); while (!sl_xfer_ack);
    rdata = sl_dbus;
    @(posedge OPB_Clk);
    #1;
    opb_select = 1'b0;
    opb_rnw    = 1'b1;
    opb_dbus   = '0;
  endtask

  task automatic count_reset(output int n);
    n = 0;
    forever begin
      @(negedge OPB_Clk);
      if (!adc_reset) break;
      n++;
    end
  endtask

  task automatic cfg_cmd(input logic [7:0] a, input logic [15:0] d);
    logic [31:0] rd;
    logic [15:0] exp_rd;
    int          writes0;
    writes0 = m_writes;
    bus_xfer(1'b0, `ADC3W_REG_CFG, 4'hF, {d, a, 8'h01}, rd);
    bus_xfer(1'b1, `ADC3W_REG_CFG, 4'hF, '0, rd);  // stalls until engine done
    check_val("status[15:0]", {16'h0, rd[15:0]}, {16'h0, a, 8'h01});
    if (a[7]) begin
      check_val("model writes", m_writes, writes0 + 1);
      check_val("model addr", {24'h0, m_addr}, {24'h0, a});
      check_val("model data", {16'h0, m_data}, {16'h0, d});
    end else begin
      check_val("model writes", m_writes, writes0);
      exp_rd = {a, ~a};
      check_val("status rdata", {16'h0, rd[31:16]}, {16'h0, exp_rd});
    end
  endtask

  ack_one_cycle: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    sl_xfer_ack |=> !sl_xfer_ack)
    else stop_run("sl_xfer_ack stayed high for two cycles");

  dbus_quiet: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    !sl_xfer_ack |-> (sl_dbus == 32'h0))
    else stop_run("sl_dbus nonzero without an acknowledge");

  initial begin
    #(TIMEOUT_NS);
    stop_run("watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] stat0;
    logic [7:0]  a;
    int          n;
    int          low_len;
    lfsr_q         = 16'd50;
    rst_n          = 1'b0;
    opb_abus       = '0;
    opb_be         = '0;
    opb_dbus       = '0;
    opb_rnw        = 1'b1;
    opb_select     = 1'b0;
    adc_dcm_locked = 1'b1;
    repeat (4) @(posedge OPB_Clk);
    #1 rst_n = 1'b1;

    @(negedge OPB_Clk);
    check_val("adc_modepin", {31'h0, adc_modepin}, 32'h1);
    check_val("adc_sclk", {31'h0, adc_sclk}, 32'h0);
    check_val("sl_xfer_ack", {31'h0, sl_xfer_ack}, 32'h0);
    check_val("adc_reset", {31'h0, adc_reset}, 32'h1);
    count_reset(n);
    check_val("reset length", n + 1, 32'd16);  // first cycle seen above

    bus_xfer(1'b0, `ADC3W_REG_CTRL, 4'h1, 32'h1, rd);
    count_reset(n);
    check_val("ctrl reset length", n + 1, 32'd16);  // ack cycle included
    bus_xfer(1'b1, `ADC3W_REG_CTRL, 4'hF, '0, rd);
    check_val("ctrl bit0 low", rd, 32'h0);
    bus_xfer(1'b0, `ADC3W_REG_CTRL, 4'h1, 32'h1, rd);
    bus_xfer(1'b1, `ADC3W_REG_CTRL, 4'hF, '0, rd);
    check_val("ctrl bit0 high", rd, 32'h1);
    count_reset(n);

    for (int i = 0; i < 6; i++) begin
      a = 8'(rand_bits(8));
      a[7] = i[0];  // alternate write and read commands
      cfg_cmd(a, rand_bits(16));
    end

    for (int i = 0; i < 3; i++) begin
      bus_xfer(1'b1, `ADC3W_REG_STAT, 4'hF, '0, stat0);
      low_len = 1 + int'(rand_bits(6));
      @(posedge OPB_Clk);
      #1 adc_dcm_locked = 1'b0;
      repeat (low_len) @(posedge OPB_Clk);
      #1 adc_dcm_locked = 1'b1;
      bus_xfer(1'b1, `ADC3W_REG_STAT, 4'hF, '0, rd);
      check_val("unlock delta", {16'h0, rd[15:0] - stat0[15:0]}, low_len);
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// File: tests/adc3w_slave_model.sv
////////////////////////////////////////
// behavioral adc three-wire serial port
////////////////////////////////////////
module adc3w_slave_model (
  input  logic        adc_sclk,
  input  logic        adc_sdata,
  input  logic        adc_modepin,
  output logic        adc_sdata_in,
  output logic [7:0]  last_addr,
  output logic [15:0] last_data,
  output int          write_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [23:0] shift_q;
  logic [15:0] resp;
  logic        reading;
  int          bit_cnt;

  initial begin
    adc_sdata_in = 1'b0;
    last_addr    = '0;
    last_data    = '0;
    write_count  = 0;
    shift_q      = '0;
    resp         = '0;
    reading      = 1'b0;
    bit_cnt      = 0;
  end

  // sclk is low when the mode pin opens a frame
  always @(posedge adc_sclk or negedge adc_modepin) begin
    if (!adc_sclk) begin
      bit_cnt = 0;  // new frame
      reading = 1'b0;
    end else if (!adc_modepin) begin
      shift_q = {shift_q[22:0], adc_sdata};
      bit_cnt++;
      if (bit_cnt == 8 && !shift_q[7]) begin
        reading = 1'b1;
        resp    = {shift_q[7:0], ~shift_q[7:0]};  // address, then its inverse
      end
      if (bit_cnt == 24 && shift_q[23]) begin
        last_addr = shift_q[23:16];
        last_data = shift_q[15:0];
        write_count++;
      end
    end
  end

  // read data goes out on falling edges, msb first
  always @(negedge adc_sclk) begin
    if (!adc_modepin && reading && bit_cnt >= 8 && bit_cnt < 24) begin
      adc_sdata_in = resp[23 - bit_cnt];
    end
  end

endmodule

// File: design/opb_adc3w_ctrl.sv
////////////////////////////////////////
// opb controller for one adc, top level
////////////////////////////////////////
module opb_adc3w_ctrl (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  input  logic [31:0] opb_abus,
  input  logic [3:0]  opb_be,
  input  logic [31:0] opb_dbus,
  input  logic        opb_rnw,
  input  logic        opb_select,
  output logic [31:0] sl_dbus,
  output logic        sl_xfer_ack,
  output logic        adc_reset,
  input  logic        adc_dcm_locked,
  output logic        adc_sclk,
  output logic        adc_sdata,
  input  logic        adc_sdata_in,
  output logic        adc_modepin
);

  adc3w_cfg_if cfg_bus ();
  adc3w_cmd_if cmd_bus ();

  opb_adc_regs regs0 (
    .OPB_Clk        (OPB_Clk),
    .rst_n          (rst_n),
    .opb_abus       (opb_abus),
    .opb_be         (opb_be),
    .opb_dbus       (opb_dbus),
    .opb_rnw        (opb_rnw),
    .opb_select     (opb_select),
    .sl_dbus        (sl_dbus),
    .sl_xfer_ack    (sl_xfer_ack),
    .adc_reset      (adc_reset),
    .adc_dcm_locked (adc_dcm_locked),
    .cfg            (cfg_bus.decoder)
  );

  adc_cmd_slot slot0 (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .cfg     (cfg_bus.slot),
    .cmd     (cmd_bus.issuer)
  );

  adc3wire_engine engine0 (
    .OPB_Clk      (OPB_Clk),
    .rst_n        (rst_n),
    .cmd          (cmd_bus.handler),
    .adc_sclk     (adc_sclk),
    .adc_sdata    (adc_sdata),
    .adc_sdata_in (adc_sdata_in),
    .adc_modepin  (adc_modepin)
  );

endmodule

// File: design/adc3wire_engine.sv
////////////////////////////////////////
// adc three-wire serial engine
// bit clock divider and shift registers
////////////////////////////////////////
`include "adc3w_defs.svh"

module adc3wire_engine (
  input  logic         OPB_Clk,
  input  logic         rst_n,
  adc3w_cmd_if.handler cmd,
  output logic         adc_sclk,
  output logic         adc_sdata,
  input  logic         adc_sdata_in,
  output logic         adc_modepin
);
  import adc3w_pkg::*;

  cfg_state_e                 state;
  logic [`ADC3W_DIV_BITS-1:0] div_cnt;
  logic                       ph_fall;
  logic                       ph_prerise;
  logic                       ph_midhigh;
  logic                       sample_en;
  cfg_cmd_t                   shift_q;
  logic [15:0]                rd_shift;
  logic [4:0]                 progress;
  logic                       writing;
  logic                       done_q;

  assign ph_fall    = (div_cnt == `ADC3W_PH_FALL);
  assign ph_prerise = (div_cnt == `ADC3W_PH_PRERISE);
  assign ph_midhigh = (div_cnt == `ADC3W_PH_MIDHIGH);

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (state == cfg_idle) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // 16 samples, progress runs 8..23
  assign sample_en = (state == cfg_data_read) && ph_prerise;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cfg_idle;
      shift_q  <= '0;
      progress <= '0;
      writing  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        cfg_idle: begin
          if (cmd.start) begin
            state   <= cfg_clkwait;
            shift_q <= cmd.cmd;
            writing <= cmd.cmd.addr[7];
          end
        end
        cfg_clkwait: begin
          if (ph_fall) begin
            state    <= cfg_data_addr;
            progress <= '0;
          end
        end
        cfg_data_addr: begin
          if (ph_fall) begin
            shift_q  <= {shift_q[22:0], 1'b0};
            progress <= progress + 1'b1;
            if (progress == 5'd7) begin
              state <= writing ? cfg_data_write : cfg_readwait;
            end
          end
        end
        cfg_data_write: begin
          if (ph_fall) begin
            shift_q  <= {shift_q[22:0], 1'b0};
            progress <= progress + 1'b1;
          end
          if (ph_midhigh && (progress == 5'd23)) begin
            state <= cfg_almost_done;
          end
        end
        cfg_readwait: begin
          if (ph_fall) begin
            state <= cfg_data_read;  // turnaround bit, clock held low
          end
        end
        cfg_data_read: begin
          if (sample_en) begin
            progress <= progress + 1'b1;
          end
          if (ph_midhigh && (progress == 5'd24)) begin
            state <= cfg_almost_done;
          end
        end
        cfg_almost_done: begin
          if (ph_prerise) begin
            state <= cfg_finish;
          end
        end
        cfg_finish: begin
          if (ph_fall) begin
            state  <= cfg_idle;
            done_q <= 1'b1;
          end
        end
        default: state <= cfg_idle;
      endcase
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if ((state == cfg_idle) && cmd.start) begin
      rd_shift <= '0;
    end else if (sample_en) begin
      rd_shift <= {rd_shift[14:0], adc_sdata_in};  // msb first
    end
  end

  assign cmd.idle  = (state == cfg_idle);
  assign cmd.rdata = rd_shift;
  assign cmd.done  = done_q;

  assign adc_sdata   = shift_q[23];
  assign adc_sclk    = div_cnt[`ADC3W_DIV_BITS-1] &&
                       (state != cfg_readwait) && (state != cfg_finish);
  assign adc_modepin = !(state inside {cfg_data_addr, cfg_data_write,
                                       cfg_readwait, cfg_data_read});

  sclk_quiet: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    (state == cfg_idle) |-> !adc_sclk);

endmodule

// File: design/adc_cmd_slot.sv
////////////////////////////////////////
// pending serial command and readback
////////////////////////////////////////
module adc_cmd_slot (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  adc3w_cfg_if.slot   cfg,
  adc3w_cmd_if.issuer cmd
);
  import adc3w_pkg::*;

  cfg_cmd_t    pend;
  logic        start_q;
  logic [15:0] rdata_q;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      pend    <= '0;
      rdata_q <= '0;
    end else begin
      start_q <= cfg.wr && cfg.be[0] && cfg.wdata[0];
      if (cfg.wr && cfg.be[1]) begin
        pend.addr <= cfg.wdata[15:8];
      end
      if (cfg.wr && cfg.be[2]) begin
        pend.data[7:0] <= cfg.wdata[23:16];
      end
      if (cfg.wr && cfg.be[3]) begin
        pend.data[15:8] <= cfg.wdata[31:24];
      end
      if (cmd.done) begin
        rdata_q <= cmd.rdata;
      end
    end
  end

  assign cmd.start = start_q;
  assign cmd.cmd   = pend;

  // held low through done so status carries the new rdata
  assign cfg.ready  = cmd.idle && !start_q && !cmd.done;
  assign cfg.status = {rdata_q, pend.addr, 7'b0, cfg.ready};

  start_when_idle: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    cmd.start |-> cmd.idle);

endmodule

// File: design/opb_adc_regs.sv
////////////////////////////////////////
// adc controller bus slave
// decode, ack, reset stretch, unlock count
////////////////////////////////////////
`include "adc3w_defs.svh"

module opb_adc_regs (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  input  logic [31:0] opb_abus,
  input  logic [3:0]  opb_be,
  input  logic [31:0] opb_dbus,
  input  logic        opb_rnw,
  input  logic        opb_select,
  output logic [31:0] sl_dbus,
  output logic        sl_xfer_ack,
  output logic        adc_reset,
  input  logic        adc_dcm_locked,
  adc3w_cfg_if.decoder cfg
);
  import adc3w_pkg::*;

  reg_sel_e    sel;
  logic [31:0] offset;
  logic        in_window;
  logic        ack_go;
  logic        rst_req;
  logic [31:0] rd_word;
  logic [31:0] dout_q;
  logic [4:0]  rst_cnt;
  logic [15:0] unlock_cnt;

  assign in_window = (opb_abus >= `ADC3W_BASE_ADDR) && (opb_abus <= `ADC3W_HIGH_ADDR);
  assign offset    = opb_abus - `ADC3W_BASE_ADDR;

  always_comb begin
    case (offset[31:2])
      `ADC3W_REG_CTRL: sel = sel_ctrl;
      `ADC3W_REG_CFG:  sel = sel_cfg;
      `ADC3W_REG_STAT: sel = sel_stat;
      default:         sel = sel_none;
    endcase
  end

  // cfg access waits for the engine
  assign ack_go = opb_select && in_window && !sl_xfer_ack &&
                  ((sel != sel_cfg) || cfg.ready);

  assign rst_req = ack_go && !opb_rnw && (sel == sel_ctrl) && opb_be[0] && opb_dbus[0];

  always_comb begin
    case (sel)
      sel_ctrl: rd_word = {31'b0, adc_reset};
      sel_cfg:  rd_word = cfg.status;
      sel_stat: rd_word = {16'b0, unlock_cnt};
      default:  rd_word = '0;
    endcase
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      sl_xfer_ack <= 1'b0;
      cfg.wr      <= 1'b0;
    end else begin
      sl_xfer_ack <= ack_go;
      cfg.wr      <= ack_go && !opb_rnw && (sel == sel_cfg);
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (ack_go) begin
      dout_q    <= opb_rnw ? rd_word : '0;
      cfg.be    <= opb_be;
      cfg.wdata <= opb_dbus;
    end
  end

  assign sl_dbus = sl_xfer_ack ? dout_q : '0;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_cnt <= `ADC3W_RST_LEN;  // pulse out of reset too
    end else if (rst_req) begin
      rst_cnt <= `ADC3W_RST_LEN;
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  assign adc_reset = (rst_cnt != '0);

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      unlock_cnt <= '0;
    end else if (!adc_dcm_locked) begin
      unlock_cnt <= unlock_cnt + 1'b1;  // wraps
    end
  end

  wr_when_ready: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    cfg.wr |-> cfg.ready);

endmodule

// File: design/adc3w_cmd_if.sv
////////////////////////////////////////
// serial command channel, slot to engine
////////////////////////////////////////
interface adc3w_cmd_if;
  import adc3w_pkg::*;

  logic        start;   // only while idle
  cfg_cmd_t    cmd;
  logic        idle;
  logic [15:0] rdata;   // valid with done
  logic        done;

  modport issuer (
    output start, cmd,
    input  idle, rdata, done
  );

  modport handler (
    input  start, cmd,
    output idle, rdata, done
  );

endinterface

// File: design/adc3w_cfg_if.sv
////////////////////////////////////////
// config register traffic, decoder to slot
////////////////////////////////////////
interface adc3w_cfg_if;

  logic        wr;      // single cycle strobe
  logic [3:0]  be;
  logic [31:0] wdata;
  logic [31:0] status;  // {rdata, addr, 7'b0, ready}
  logic        ready;

  modport decoder (
    output wr, be, wdata,
    input  status, ready
  );

  modport slot (
    input  wr, be, wdata,
    output status, ready
  );

endinterface

// File: design/adc3w_pkg.sv
////////////////////////////////////////
// adc three-wire controller types
////////////////////////////////////////
package adc3w_pkg;

  typedef enum logic [3:0] {
    cfg_idle,
    cfg_clkwait,
    cfg_readwait,
    cfg_data_addr,
    cfg_data_write,
    cfg_data_read,
    cfg_almost_done,
    cfg_finish
  } cfg_state_e;

  typedef enum logic [1:0] {
    sel_ctrl,
    sel_cfg,
    sel_stat,
    sel_none
  } reg_sel_e;

  typedef struct packed {
    logic [7:0]  addr;   // bit 7 set for write
    logic [15:0] data;
  } cfg_cmd_t;

endpackage

// File: design/adc3w_defs.svh
////////////////////////////////////////
// adc three-wire controller constants
// bus window, register map, serial timing
////////////////////////////////////////
`ifndef ADC3W_DEFS_SVH
`define ADC3W_DEFS_SVH

`define ADC3W_BASE_ADDR 32'h0001_0000
`define ADC3W_HIGH_ADDR 32'h0001_FFFF

`define ADC3W_REG_CTRL 30'd0
`define ADC3W_REG_CFG 30'd1
`define ADC3W_REG_STAT 30'd2

`define ADC3W_DIV_BITS 5     // 32 bus clocks per serial bit
`define ADC3W_PH_FALL 5'd0
`define ADC3W_PH_PRERISE 5'd15
`define ADC3W_PH_MIDHIGH 5'd24

`define ADC3W_RST_LEN 5'd16

`endif
